/* source/sdram_sched_pkg.sv */
package sdram_sched_pkg;

  //////////////////////////////
  // Geometry
  //////////////////////////////
  localparam int BA_W  = 2;
  localparam int BANKS = 4;
  localparam int ROW_W = 13;
  localparam int COL_W = 10;
  localparam int DQ_W  = 16;

  //////////////////////////////
  // Timing in clock cycles
  //////////////////////////////
  localparam int T_RCD   = 2;
  localparam int T_RP    = 2;
  localparam int T_RAS   = 5;
  localparam int T_RC    = 6;
  localparam int CAS_LAT = 2;

  // Shortened refresh period for simulation
  localparam int REF_INTERVAL = 200;

  localparam int TIMER_W   = 4;
  localparam int REF_CNT_W = 8;

  typedef logic [BA_W-1:0]  ba_t;
  typedef logic [ROW_W-1:0] row_t;
  typedef logic [COL_W-1:0] col_t;
  typedef logic [DQ_W-1:0]  dq_t;

  // RAS_n, CAS_n, WE_n as driven on the pins
  typedef enum logic [2:0] {
    CMD_NOP = 3'b111,
    CMD_ACT = 3'b011,
    CMD_RD  = 3'b101,
    CMD_WR  = 3'b100,
    CMD_PRE = 3'b010,
    CMD_REF = 3'b001
  } sdram_cmd_e;

  typedef enum logic [1:0] {
    REQ_NONE = 2'd0,
    REQ_HIT  = 2'd1,
    REQ_ACT  = 2'd2,
    REQ_PRE  = 2'd3
  } req_kind_e;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_REF  = 1'b1
  } sched_state_e;

endpackage

/* source/sdram_bank_tracker.sv */
`timescale 1ns/1ps

module sdram_bank_tracker
  import sdram_sched_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,

  input  sdram_cmd_e         cmd_i,
  input  ba_t                ba_i,
  input  row_t               row_i,
  input  logic               all_i,

  output logic [BANKS-1:0]   open_o,
  output row_t               open_row_o [BANKS],
  output logic [BANKS-1:0]   act_ok_o,
  output logic [BANKS-1:0]   rdwr_ok_o,
  output logic [BANKS-1:0]   pre_ok_o,
  output logic               all_idle_o,
  output logic               all_act_ok_o
);

  // Counters start one cycle after the command is on the bus, and the
  // next command is decided one cycle before it appears
  localparam logic [TIMER_W-1:0] RCD_LOAD = TIMER_W'(T_RCD - 2);
  localparam logic [TIMER_W-1:0] RAS_LOAD = TIMER_W'(T_RAS - 2);
  localparam logic [TIMER_W-1:0] RP_LOAD  = TIMER_W'(T_RP - 2);

  for (genvar b = 0; b < BANKS; b++)
  begin : gen_bank
    logic               sel;
    logic               act_hit;
    logic               pre_hit;
    logic               open_q;
    row_t               row_q;
    logic [TIMER_W-1:0] rcd_cnt;
    logic [TIMER_W-1:0] ras_cnt;
    logic [TIMER_W-1:0] rp_cnt;

    assign sel     = (ba_i == ba_t'(b));
    assign act_hit = (cmd_i == CMD_ACT) && sel;
    // PRE with A10 high closes every bank
    assign pre_hit = (cmd_i == CMD_PRE) && (all_i || sel);

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        open_q  <= 1'b0;
        rcd_cnt <= '0;
        ras_cnt <= '0;
        rp_cnt  <= '0;
      end
      else
      begin
        if (act_hit)
        begin
          open_q  <= 1'b1;
          rcd_cnt <= RCD_LOAD;
          ras_cnt <= RAS_LOAD;
        end
        else
        begin
          if (pre_hit)
            open_q <= 1'b0;
          if (rcd_cnt != '0)
            rcd_cnt <= rcd_cnt - 1'b1;
          if (ras_cnt != '0)
            ras_cnt <= ras_cnt - 1'b1;
        end

        if (pre_hit)
          rp_cnt <= RP_LOAD;
        else if (rp_cnt != '0)
          rp_cnt <= rp_cnt - 1'b1;
      end
    end

    // Row of the last ACT to this bank
    always_ff @(posedge clk_i)
    begin
      if (act_hit)
        row_q <= row_i;
    end

    assign open_o[b]     = open_q;
    assign open_row_o[b] = row_q;
    assign act_ok_o[b]   = (rp_cnt == '0);
    assign rdwr_ok_o[b]  = (rcd_cnt == '0);
    assign pre_ok_o[b]   = (ras_cnt == '0);
  end

  assign all_idle_o   = ~|open_o;
  // Every bank past tRP and tRAS, so PRE-all or REF may go
  assign all_act_ok_o = &(act_ok_o & pre_ok_o);

endmodule

/* source/sdram_refresh_timer.sv */
`timescale 1ns/1ps

module sdram_refresh_timer
  import sdram_sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  sdram_cmd_e cmd_i,
  output logic       ref_due_o,
  output logic       rc_ok_o
);

  localparam logic [REF_CNT_W-1:0] REF_LOAD = REF_CNT_W'(REF_INTERVAL - 1);
  localparam logic [TIMER_W-1:0]   RC_LOAD  = TIMER_W'(T_RC - 2);

  logic [REF_CNT_W-1:0] ref_cnt;
  logic [TIMER_W-1:0]   rc_cnt;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ref_cnt   <= REF_LOAD;
      ref_due_o <= 1'b0;
      rc_cnt    <= '0;
    end
    else
    begin
      // A new interval wins over a REF in the same cycle
      if (ref_cnt == '0)
      begin
        ref_cnt   <= REF_LOAD;
        ref_due_o <= 1'b1;
      end
      else
      begin
        ref_cnt <= ref_cnt - 1'b1;
        if (cmd_i == CMD_REF)
          ref_due_o <= 1'b0;
      end

      if (cmd_i == CMD_REF)
        rc_cnt <= RC_LOAD;
      else if (rc_cnt != '0)
        rc_cnt <= rc_cnt - 1'b1;
    end
  end

  assign rc_ok_o = (rc_cnt == '0);

endmodule

/* source/sdram_req_decode.sv */
`timescale 1ns/1ps

module sdram_req_decode
  import sdram_sched_pkg::*;
(
  input  logic             req_i,
  input  ba_t              ba_i,
  input  row_t             row_i,

  input  logic [BANKS-1:0] open_i,
  input  row_t             open_row_i [BANKS],
  input  logic [BANKS-1:0] act_ok_i,
  input  logic [BANKS-1:0] rdwr_ok_i,
  input  logic [BANKS-1:0] pre_ok_i,

  output req_kind_e        kind_o,
  output logic             ready_o
);

  logic row_match;

  assign row_match = (open_row_i[ba_i] == row_i);

  always_comb
  begin
    kind_o  = REQ_NONE;
    ready_o = 1'b0;
    if (req_i)
    begin
      if (!open_i[ba_i])
      begin
        // Bank precharged
        kind_o  = REQ_ACT;
        ready_o = act_ok_i[ba_i];
      end
      else if (row_match)
      begin
        kind_o  = REQ_HIT;
        ready_o = rdwr_ok_i[ba_i];
      end
      else
      begin
        // Row conflict
        kind_o  = REQ_PRE;
        ready_o = pre_ok_i[ba_i];
      end
    end
  end

endmodule

/* source/sdram_cmd_exec.sv */
`timescale 1ns/1ps

module sdram_cmd_exec
  import sdram_sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       req_i,
  input  logic       we_i,
  input  ba_t        ba_i,
  input  row_t       row_i,
  input  col_t       col_i,

  input  req_kind_e  kind_i,
  input  logic       ready_i,
  input  logic       all_idle_i,
  input  logic       all_act_ok_i,
  input  logic       ref_due_i,
  input  logic       rc_ok_i,

  output sdram_cmd_e cmd_nxt_o,
  output sdram_cmd_e cmd_o,
  output ba_t        ba_o,
  output row_t       addr_o,
  output logic       ack_o
);

  sched_state_e state_q;
  sched_state_e state_d;
  ba_t          ba_d;
  row_t         addr_d;
  logic         ack_d;

  //////////////////////////////
  // Next command
  //////////////////////////////
  always_comb
  begin
    state_d   = state_q;
    cmd_nxt_o = CMD_NOP;
    ba_d      = ba_o;
    addr_d    = addr_o;
    ack_d     = 1'b0;

    // Bank state follows the bus a cycle late, so leave a gap after
    // every command. This also keeps an acked request from going twice
    if (cmd_o == CMD_NOP)
    begin
      case (state_q)
        ST_IDLE:
          if (ref_due_i)
          begin
            // Refresh first; requests wait
            if (all_act_ok_i && rc_ok_i)
            begin
              if (all_idle_i)
                cmd_nxt_o = CMD_REF;
              else
              begin
                cmd_nxt_o  = CMD_PRE;
                addr_d[10] = 1'b1;
                state_d    = ST_REF;
              end
            end
          end
          else if (req_i && ready_i)
          begin
            case (kind_i)
              REQ_HIT:
              begin
                cmd_nxt_o = we_i ? CMD_WR : CMD_RD;
                ba_d      = ba_i;
                // Column on A9..A0, A10 low so no auto-precharge
                addr_d    = row_t'(col_i);
                ack_d     = 1'b1;
              end
              REQ_ACT:
                if (rc_ok_i)
                begin
                  cmd_nxt_o = CMD_ACT;
                  ba_d      = ba_i;
                  addr_d    = row_i;
                end
              REQ_PRE:
              begin
                cmd_nxt_o  = CMD_PRE;
                ba_d       = ba_i;
                addr_d[10] = 1'b0;
              end
              default: ;
            endcase
          end

        ST_REF:
          // REF once every bank is past tRP
          if (all_act_ok_i && rc_ok_i)
          begin
            cmd_nxt_o = CMD_REF;
            state_d   = ST_IDLE;
          end

        default: state_d = ST_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Command registers
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= ST_IDLE;
      cmd_o   <= CMD_NOP;
      ack_o   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      cmd_o   <= cmd_nxt_o;
      ack_o   <= ack_d;
    end
  end

  always_ff @(posedge clk_i)
  begin
    ba_o   <= ba_d;
    addr_o <= addr_d;
  end

endmodule

/* source/sdram_rd_result.sv */
`timescale 1ns/1ps

module sdram_rd_result
  import sdram_sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  sdram_cmd_e cmd_i,
  input  dq_t        wdata_i,
  input  dq_t        dq_i,
  output dq_t        dq_o,
  output logic       dqoe_o,
  output logic       rdvalid_o,
  output dq_t        rdata_o
);

  // Bit 0 is set while RD is on the bus, bit CAS_LAT when data returns
  logic [CAS_LAT:0] rd_sr;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rd_sr  <= '0;
      dqoe_o <= 1'b0;
    end
    else
    begin
      rd_sr  <= {rd_sr[CAS_LAT-1:0], cmd_i == CMD_RD};
      dqoe_o <= (cmd_i == CMD_WR);
    end
  end

  // Write data goes out together with WR
  always_ff @(posedge clk_i)
  begin
    if (cmd_i == CMD_WR)
      dq_o <= wdata_i;
  end

  assign rdvalid_o = rd_sr[CAS_LAT];
  assign rdata_o   = dq_i;

endmodule

/* source/sdram_sched_top.sv */
`timescale 1ns/1ps

module sdram_sched_top
  import sdram_sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // Request side
  input  logic       req_i,
  input  logic       we_i,
  input  ba_t        ba_i,
  input  row_t       row_i,
  input  col_t       col_i,
  input  dq_t        wdata_i,
  output logic       ack_o,
  output dq_t        rdata_o,
  output logic       rdvalid_o,

  // SDRAM side
  output sdram_cmd_e cmd_o,
  output ba_t        ba_o,
  output row_t       addr_o,
  output dq_t        dq_o,
  output logic       dqoe_o,
  input  dq_t        dq_i
);

  req_kind_e        kind;
  logic             ready;
  logic [BANKS-1:0] bank_open;
  row_t             bank_row [BANKS];
  logic [BANKS-1:0] act_ok;
  logic [BANKS-1:0] rdwr_ok;
  logic [BANKS-1:0] pre_ok;
  logic             all_idle;
  logic             all_act_ok;
  logic             ref_due;
  logic             rc_ok;
  sdram_cmd_e       cmd_nxt;

  sdram_req_decode u_req_decode (
    .req_i      (req_i),
    .ba_i       (ba_i),
    .row_i      (row_i),
    .open_i     (bank_open),
    .open_row_i (bank_row),
    .act_ok_i   (act_ok),
    .rdwr_ok_i  (rdwr_ok),
    .pre_ok_i   (pre_ok),
    .kind_o     (kind),
    .ready_o    (ready)
  );

  sdram_cmd_exec u_cmd_exec (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .we_i         (we_i),
    .ba_i         (ba_i),
    .row_i        (row_i),
    .col_i        (col_i),
    .kind_i       (kind),
    .ready_i      (ready),
    .all_idle_i   (all_idle),
    .all_act_ok_i (all_act_ok),
    .ref_due_i    (ref_due),
    .rc_ok_i      (rc_ok),
    .cmd_nxt_o    (cmd_nxt),
    .cmd_o        (cmd_o),
    .ba_o         (ba_o),
    .addr_o       (addr_o),
    .ack_o        (ack_o)
  );

  sdram_rd_result u_rd_result (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cmd_i     (cmd_nxt),
    .wdata_i   (wdata_i),
    .dq_i      (dq_i),
    .dq_o      (dq_o),
    .dqoe_o    (dqoe_o),
    .rdvalid_o (rdvalid_o),
    .rdata_o   (rdata_o)
  );

  // Trackers follow the command as it appears on the bus
  sdram_bank_tracker u_bank_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd_o),
    .ba_i         (ba_o),
    .row_i        (addr_o),
    .all_i        (addr_o[10]),
    .open_o       (bank_open),
    .open_row_o   (bank_row),
    .act_ok_o     (act_ok),
    .rdwr_ok_o    (rdwr_ok),
    .pre_ok_o     (pre_ok),
    .all_idle_o   (all_idle),
    .all_act_ok_o (all_act_ok)
  );

  sdram_refresh_timer u_refresh_timer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cmd_i     (cmd_o),
    .ref_due_o (ref_due),
    .rc_ok_o   (rc_ok)
  );

endmodule

/* test/tb_sdram_sched.sv */
`timescale 1ns/1ps

module tb_sdram_sched
  import sdram_sched_pkg::*;
();

  localparam logic [31:0] SEED = 32'h6a7b;
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_CYCLES  = 6;
  localparam int N_ENTRIES    = 12;
  localparam int PASSES       = 10;
  localparam int ACK_TIMEOUT  = 60;
  localparam int RD_TIMEOUT   = 10;
  localparam int REF_MARGIN   = 20;
  localparam int MIN_REFS     = 2;
  localparam int KEY_W        = BA_W + ROW_W + COL_W;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       req;
  logic       we;
  ba_t        ba;
  row_t       row;
  col_t       col;
  dq_t        wdata;
  logic       ack;
  dq_t        rdata;
  logic       rdvalid;
  sdram_cmd_e cmd;
  ba_t        cmd_ba;
  row_t       addr;
  dq_t        dq_out;
  logic       dqoe;
  dq_t        dq_in = '0;

  // The data column holds write data or expected read data
  logic tab_we   [N_ENTRIES];
  ba_t  tab_ba   [N_ENTRIES];
  row_t tab_row  [N_ENTRIES];
  col_t tab_col  [N_ENTRIES];
  dq_t  tab_data [N_ENTRIES];

  // SDRAM model and monitor state
  dq_t              mem [logic [KEY_W-1:0]];
  logic             mdl_open [BANKS];
  row_t             mdl_row  [BANKS];
  int               act_cyc  [BANKS];
  int               pre_cyc  [BANKS];
  int               ref_cyc;
  int               cyc;
  int               since_ref;
  int               act_cnt;
  int               pre_cnt;
  int               ref_count;
  int               ack_total;
  logic [CAS_LAT:1] rd_hist;
  dq_t              dq_pipe [CAS_LAT];

  // Row state predicted from the request stream
  logic exp_open [BANKS];
  row_t exp_row  [BANKS];
  int   seen_refs;

  always #20 clk = ~clk;

  sdram_sched_top UUT (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .req_i     (req),
    .we_i      (we),
    .ba_i      (ba),
    .row_i     (row),
    .col_i     (col),
    .wdata_i   (wdata),
    .ack_o     (ack),
    .rdata_o   (rdata),
    .rdvalid_o (rdvalid),
    .cmd_o     (cmd),
    .ba_o      (cmd_ba),
    .addr_o    (addr),
    .dq_o      (dq_out),
    .dqoe_o    (dqoe),
    .dq_i      (dq_in)
  );

  //////////////////////////////
  // Error reporting
  //////////////////////////////
  task automatic stop_run();
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    stop_run();
  endtask

  task automatic report_problem(input string msg);
    $display("** Error: %s", msg);
    stop_run();
  endtask

  // Unwritten locations return a pattern of their address
  function automatic dq_t read_mem(input logic [KEY_W-1:0] key);
    if (mem.exists(key))
      return mem[key];
    return dq_t'(key) ^ dq_t'(key >> DQ_W);
  endfunction

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  task automatic set_entry(input int idx, input logic wr, input ba_t b, input row_t r,
                           input col_t c, input int src);
    tab_we[idx]   = wr;
    tab_ba[idx]   = b;
    tab_row[idx]  = r;
    tab_col[idx]  = c;
    tab_data[idx] = wr ? dq_t'($urandom) : tab_data[src];
  endtask

  // Rows shift each pass so a pass starts with conflicts
  task automatic fill_table(input int pass);
    row_t ofs;
    ofs = row_t'(pass);
    set_entry(0,  1'b1, 2'd0, 13'd5 + ofs,  10'd1, 0);
    set_entry(1,  1'b1, 2'd0, 13'd5 + ofs,  10'd2, 0);
    set_entry(2,  1'b1, 2'd1, 13'd7 + ofs,  10'd3, 0);
    set_entry(3,  1'b1, 2'd2, 13'd9 + ofs,  10'd4, 0);
    set_entry(4,  1'b1, 2'd3, 13'd11 + ofs, 10'd5, 0);
    set_entry(5,  1'b1, 2'd0, 13'd6 + ofs,  10'd6, 0);
    set_entry(6,  1'b0, 2'd1, 13'd7 + ofs,  10'd3, 2);
    set_entry(7,  1'b0, 2'd0, 13'd6 + ofs,  10'd6, 5);
    set_entry(8,  1'b0, 2'd0, 13'd5 + ofs,  10'd1, 0);
    set_entry(9,  1'b0, 2'd0, 13'd5 + ofs,  10'd2, 1);
    set_entry(10, 1'b0, 2'd2, 13'd9 + ofs,  10'd4, 3);
    set_entry(11, 1'b0, 2'd3, 13'd11 + ofs, 10'd5, 4);
  endtask

  task automatic check_idle();
    repeat (IDLE_CYCLES)
    begin
      @(posedge clk);
      assert (cmd == CMD_NOP) else report_value("cmd_o", cmd, CMD_NOP);
      assert (!ack) else report_value("ack_o", ack, 0);
      assert (!rdvalid) else report_value("rdvalid_o", rdvalid, 0);
      assert (!dqoe) else report_value("dqoe_o", dqoe, 0);
    end
  endtask

  // A refresh closes every bank
  task automatic sync_refresh();
    if (ref_count != seen_refs)
    begin
      for (int b = 0; b < BANKS; b++)
        exp_open[b] = 1'b0;
      seen_refs = ref_count;
    end
  endtask

  task automatic run_request(input int idx);
    int   wait_cnt;
    int   exp_act;
    int   exp_pre;
    int   ref_start;
    logic done;
    ba_t  b;
    b = tab_ba[idx];
    sync_refresh();
    if (!exp_open[b])
    begin
      exp_act = 1;
      exp_pre = 0;
    end
    else if (exp_row[b] == tab_row[idx])
    begin
      exp_act = 0;
      exp_pre = 0;
    end
    else
    begin
      exp_act = 1;
      exp_pre = 1;
    end
    ref_start = ref_count;
    act_cnt   = 0;
    pre_cnt   = 0;
    req   = 1'b1;
    we    = tab_we[idx];
    ba    = b;
    row   = tab_row[idx];
    col   = tab_col[idx];
    wdata = tab_we[idx] ? tab_data[idx] : dq_t'($urandom);

    done     = 1'b0;
    wait_cnt = 0;
    while (!done)
    begin
      @(posedge clk);
      if (ack)
        done = 1'b1;
      else
      begin
        wait_cnt++;
        if (wait_cnt > ACK_TIMEOUT)
          report_problem("Timeout waiting for ack_o");
      end
    end
    @(negedge clk);
    req = 1'b0;

    // Counts are only predictable when no refresh cut in
    if (ref_count == ref_start)
    begin
      assert (act_cnt == exp_act) else report_value("ACT count on cmd_o", act_cnt, exp_act);
      assert (pre_cnt == exp_pre) else report_value("PRE count on cmd_o", pre_cnt, exp_pre);
    end
    sync_refresh();
    exp_open[b] = 1'b1;
    exp_row[b]  = tab_row[idx];

    if (!tab_we[idx])
    begin
      done     = 1'b0;
      wait_cnt = 0;
      while (!done)
      begin
        @(posedge clk);
        if (rdvalid)
          done = 1'b1;
        else
        begin
          wait_cnt++;
          if (wait_cnt > RD_TIMEOUT)
            report_problem("Timeout waiting for rdvalid_o");
        end
      end
      assert (rdata == tab_data[idx]) else report_value("rdata_o", rdata, tab_data[idx]);
      @(negedge clk);
    end
    repeat ($urandom_range(3, 0)) @(negedge clk);
  endtask

  //////////////////////////////
  // Bus monitor and memory model
  //////////////////////////////
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      cyc       = 0;
      ref_cyc   = -100;
      ref_count = 0;
      ack_total = 0;
      rd_hist   = '0;
      for (int b = 0; b < BANKS; b++)
      begin
        mdl_open[b] = 1'b0;
        act_cyc[b]  = -100;
        pre_cyc[b]  = -100;
      end
      for (int i = 0; i < CAS_LAT; i++)
        dq_pipe[i] = '0;
    end
    else
    begin
      cyc = cyc + 1;
      assert (rdvalid == rd_hist[CAS_LAT])
        else report_value("rdvalid_o", rdvalid, rd_hist[CAS_LAT]);
      assert (ack == (cmd == CMD_RD || cmd == CMD_WR))
        else report_value("ack_o", ack, cmd == CMD_RD || cmd == CMD_WR);
      assert (!(ack && !req)) else report_problem("ack_o rose while req_i was low");
      assert (dqoe == (cmd == CMD_WR)) else report_value("dqoe_o", dqoe, cmd == CMD_WR);
      since_ref = (ref_count == 0) ? cyc : cyc - ref_cyc;
      assert (since_ref <= REF_INTERVAL + REF_MARGIN)
        else report_problem("No REF issued within the refresh interval");
      if (ack)
        ack_total++;

      rd_hist = {rd_hist[CAS_LAT-1:1], cmd == CMD_RD};
      for (int i = CAS_LAT - 1; i > 0; i--)
        dq_pipe[i] = dq_pipe[i-1];
      dq_pipe[0] = '0;

      case (cmd)
        CMD_ACT:
        begin
          assert (!mdl_open[cmd_ba]) else report_problem("ACT to a bank that is already open");
          assert (cyc - pre_cyc[cmd_ba] >= T_RP) else report_problem("ACT too soon after PRE");
          assert (cyc - ref_cyc >= T_RC) else report_problem("ACT too soon after REF");
          mdl_open[cmd_ba] = 1'b1;
          mdl_row[cmd_ba]  = addr;
          act_cyc[cmd_ba]  = cyc;
          act_cnt++;
        end
        CMD_RD, CMD_WR:
        begin
          assert (mdl_open[cmd_ba]) else report_problem("RD or WR to a closed bank");
          assert (cyc - act_cyc[cmd_ba] >= T_RCD)
            else report_problem("RD or WR too soon after ACT");
          if (cmd == CMD_WR)
          begin
            assert (dq_out == wdata) else report_value("dq_o", dq_out, wdata);
            mem[{cmd_ba, mdl_row[cmd_ba], addr[COL_W-1:0]}] = dq_out;
          end
          else
            dq_pipe[0] = read_mem({cmd_ba, mdl_row[cmd_ba], addr[COL_W-1:0]});
        end
        CMD_PRE:
        begin
          for (int b = 0; b < BANKS; b++)
          begin
            if (addr[10] || cmd_ba == ba_t'(b))
            begin
              assert (addr[10] || mdl_open[b])
                else report_problem("PRE to a bank that is already closed");
              assert (!mdl_open[b] || cyc - act_cyc[b] >= T_RAS)
                else report_problem("PRE too soon after ACT");
              mdl_open[b] = 1'b0;
              pre_cyc[b]  = cyc;
            end
          end
          if (!addr[10])
            pre_cnt++;
        end
        CMD_REF:
        begin
          for (int b = 0; b < BANKS; b++)
          begin
            assert (!mdl_open[b]) else report_problem("REF while a bank is open");
            assert (cyc - pre_cyc[b] >= T_RP) else report_problem("REF too soon after PRE");
          end
          assert (cyc - ref_cyc >= T_RC) else report_problem("REF too soon after REF");
          ref_cyc = cyc;
          ref_count++;
        end
        default: ;
      endcase
    end
  end

  // Read data reaches the pins CAS_LAT cycles after RD
  always @(negedge clk)
    dq_in <= dq_pipe[CAS_LAT-1];

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial
  begin
    void'($urandom(SEED));
    rst_n     = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    ba        = '0;
    row       = '0;
    col       = '0;
    wdata     = '0;
    seen_refs = 0;
    for (int b = 0; b < BANKS; b++)
      exp_open[b] = 1'b0;

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    check_idle();
    @(negedge clk);

    for (int pass = 0; pass < PASSES; pass++)
    begin
      fill_table(pass);
      for (int i = 0; i < N_ENTRIES; i++)
        run_request(i);
    end

    assert (ref_count >= MIN_REFS)
      else report_problem("Fewer REF commands than expected over the run");

    if (ack_total == PASSES * N_ENTRIES)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
      report_value("ack_o pulse count", ack_total, PASSES * N_ENTRIES);
  end

endmodule

/* sdram_sched.f */
source/sdram_sched_pkg.sv
source/sdram_bank_tracker.sv
source/sdram_refresh_timer.sv
source/sdram_req_decode.sv
source/sdram_cmd_exec.sv
source/sdram_rd_result.sv
source/sdram_sched_top.sv
test/tb_sdram_sched.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scheduler testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sdram_sched -f sdram_sched.f -o sim_sdram_sched &&
./obj_dir/sim_sdram_sched || {
  echo "Simulation reported a failure"
  exit 1
}
